/* include/rv_dec_defs.svh */
// rv32 decode stage constants: data width, register count, opcodes and custom funct3 codes
`ifndef RV_DEC_DEFS_SVH
`define RV_DEC_DEFS_SVH

// datapath and register file size
`define XLEN_W 32
`define REG_N  32

// accepted major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_CUSTOM0 7'b0001011

// custom-0 funct3 codes, funct7 must be zero
`define F3_CNTZ  3'b000
`define F3_CNTP  3'b001
`define F3_RVRS  3'b010
`define F3_HMDST 3'b011
`define F3_PKG   3'b100
`define F3_SLADD 3'b101

`endif

/* design/rv_dec_pkg.sv */
// shared types of the decode stage: micro-op codes, decoded op, execute op and result
`include "rv_dec_defs.svh"

package rv_dec_pkg;

    // illegal sits at zero so a cleared register reads as no operation
    typedef enum logic [4:0] {
        UOP_ILLEGAL = 5'd0,
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_SLL,
        UOP_SRL,
        UOP_SRA,
        UOP_SLT,
        UOP_SLTU,
        UOP_ADDI,
        UOP_ANDI,
        UOP_ORI,
        UOP_XORI,
        UOP_SLTI,
        UOP_SLTIU,
        UOP_SLLI,
        UOP_SRLI,
        UOP_SRAI,
        UOP_LUI,
        UOP_CNTZ,
        UOP_CNTP,
        UOP_RVRS,
        UOP_HMDST,
        UOP_PKG,
        UOP_SLADD
    } uop_e;

    typedef struct packed {
        uop_e              uop;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [`XLEN_W-1:0] imm;
        logic              use_imm;
        logic              iter;
    } dec_op_t;

    // decoded op together with both register operands
    typedef struct packed {
        dec_op_t           op;
        logic [`XLEN_W-1:0] a;
        logic [`XLEN_W-1:0] b;
    } exec_op_t;

    typedef struct packed {
        logic [4:0]        rd;
        logic [`XLEN_W-1:0] value;
        logic              illegal;
    } result_t;

endpackage

/* design/instr_decoder.sv */
// instruction decoder: maps a 32-bit rv32 word onto a decoded micro-op with operands
`timescale 1ns/1ps
`include "rv_dec_defs.svh"

module instr_decoder (
    input  logic [31:0]         instr_i,
    output rv_dec_pkg::dec_op_t dec_o
);
    import rv_dec_pkg::*;

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [`XLEN_W-1:0] i_imm;
    logic [`XLEN_W-1:0] u_imm;
    uop_e               uop;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign i_imm  = {{(`XLEN_W-12){instr_i[31]}}, instr_i[31:20]};
    assign u_imm  = {instr_i[31:12], 12'b0};

    // anything not matched below stays illegal
    always_comb begin
        uop = UOP_ILLEGAL;
        case (opcode)
            `OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: uop = UOP_ADD;
                        3'b001: uop = UOP_SLL;
                        3'b010: uop = UOP_SLT;
                        3'b011: uop = UOP_SLTU;
                        3'b100: uop = UOP_XOR;
                        3'b101: uop = UOP_SRL;
                        3'b110: uop = UOP_OR;
                        default: uop = UOP_AND;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000) begin
                        uop = UOP_SUB;
                    end else if (funct3 == 3'b101) begin
                        uop = UOP_SRA;
                    end
                end
            end
            `OPC_OP_IMM: begin
                case (funct3)
                    3'b000: uop = UOP_ADDI;
                    3'b010: uop = UOP_SLTI;
                    3'b011: uop = UOP_SLTIU;
                    3'b100: uop = UOP_XORI;
                    3'b110: uop = UOP_ORI;
                    3'b111: uop = UOP_ANDI;
                    3'b001: begin
                        if (funct7 == 7'b0000000) uop = UOP_SLLI;
                    end
                    default: begin
                        // shift right, funct7 picks logical or arithmetic
                        if (funct7 == 7'b0000000) begin
                            uop = UOP_SRLI;
                        end else if (funct7 == 7'b0100000) begin
                            uop = UOP_SRAI;
                        end
                    end
                endcase
            end
            `OPC_LUI: uop = UOP_LUI;
            `OPC_CUSTOM0: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        `F3_CNTZ:  uop = UOP_CNTZ;
                        `F3_CNTP:  uop = UOP_CNTP;
                        `F3_RVRS:  uop = UOP_RVRS;
                        `F3_HMDST: uop = UOP_HMDST;
                        `F3_PKG:   uop = UOP_PKG;
                        `F3_SLADD: uop = UOP_SLADD;
                        default:   uop = UOP_ILLEGAL;
                    endcase
                end
            end
            default: uop = UOP_ILLEGAL;
        endcase
    end

    always_comb begin
        dec_o.uop     = uop;
        dec_o.rd      = instr_i[11:7];
        dec_o.rs1     = instr_i[19:15];
        dec_o.rs2     = instr_i[24:20];
        dec_o.use_imm = (uop != UOP_ILLEGAL) && (opcode == `OPC_OP_IMM || opcode == `OPC_LUI);
        dec_o.imm     = (opcode == `OPC_LUI) ? u_imm : i_imm;
        dec_o.iter    = (uop == UOP_CNTZ) || (uop == UOP_CNTP) ||
                        (uop == UOP_RVRS) || (uop == UOP_HMDST);
    end

    // the iterative path only starts from a legal custom-0 word with funct3 below 4
    iter_legal_a: assert final (!dec_o.iter ||
        (opcode == `OPC_CUSTOM0 && funct7 == 7'b0000000 && !funct3[2]))
        else $error("iterative flag set on a word that is not an iterative op");

endmodule

/* design/reg_file.sv */
// integer register file: two combinational read ports and one write port, x0 reads zero
`timescale 1ns/1ps
`include "rv_dec_defs.svh"

module reg_file (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic [4:0]         rd_addr_a_i,
    input  logic [4:0]         rd_addr_b_i,
    output logic [`XLEN_W-1:0] rd_data_a_o,
    output logic [`XLEN_W-1:0] rd_data_b_o,
    input  logic               wr_en_i,
    input  logic [4:0]         wr_addr_i,
    input  logic [`XLEN_W-1:0] wr_data_i
);
    // x0 has no storage
    logic [`XLEN_W-1:0] regs_q [1:`REG_N-1];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < `REG_N; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != 5'd0) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    assign rd_data_a_o = (rd_addr_a_i == 5'd0) ? '0 : regs_q[rd_addr_a_i];
    assign rd_data_b_o = (rd_addr_b_i == 5'd0) ? '0 : regs_q[rd_addr_b_i];

endmodule

/* design/issue_ctrl.sv */
// issue controller: accepts one instruction, sequences decode, execute and result handshake
`timescale 1ns/1ps
`include "rv_dec_defs.svh"

module issue_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 instr_valid_i,
    input  logic [31:0]          instr_i,
    output logic                 instr_ready_o,
    input  rv_dec_pkg::dec_op_t  dec_i,
    input  logic [`XLEN_W-1:0]   rs1_val_i,
    input  logic [`XLEN_W-1:0]   rs2_val_i,
    output rv_dec_pkg::exec_op_t exec_o,
    input  logic [`XLEN_W-1:0]   alu_val_i,
    output logic                 iter_load_o,
    output logic                 iter_step_o,
    input  logic [`XLEN_W-1:0]   iter_val_i,
    output logic                 cnt_clear_o,
    input  logic                 cnt_last_i,
    output logic                 res_valid_o,
    output rv_dec_pkg::result_t  res_o,
    input  logic                 res_ready_i,
    output logic                 wr_en_o,
    output logic [4:0]           wr_addr_o,
    output logic [`XLEN_W-1:0]   wr_data_o,
    output logic [31:0]          instr_o
);
    import rv_dec_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_DECODE,
        S_EXEC,
        S_ITER,
        S_DONE
    } state_e;

    state_e      state_q;
    state_e      state_d;
    logic [31:0] instr_q;
    exec_op_t    exec_q;
    result_t     res_q;
    logic        exec_illegal;

    assign exec_illegal = (exec_q.op.uop == UOP_ILLEGAL);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:   if (instr_valid_i) state_d = S_DECODE;
            S_DECODE: state_d = S_EXEC;
            S_EXEC:   state_d = exec_q.op.iter ? S_ITER : S_DONE;
            S_ITER:   if (cnt_last_i) state_d = S_DONE;
            S_DONE:   if (res_ready_i) state_d = S_IDLE;
            default:  state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            instr_q <= '0;
            exec_q  <= '0;
            res_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == S_IDLE && instr_valid_i) begin
                instr_q <= instr_i;
            end
            if (state_q == S_DECODE) begin
                exec_q <= '{op: dec_i, a: rs1_val_i, b: rs2_val_i};
            end
            // single-cycle and illegal ops finish here
            if (state_q == S_EXEC && !exec_q.op.iter) begin
                res_q.rd      <= exec_q.op.rd;
                res_q.value   <= exec_illegal ? '0 : alu_val_i;
                res_q.illegal <= exec_illegal;
            end
            // iter value already includes the final step
            if (state_q == S_ITER && cnt_last_i) begin
                res_q.rd      <= exec_q.op.rd;
                res_q.value   <= iter_val_i;
                res_q.illegal <= 1'b0;
            end
        end
    end

    assign instr_ready_o = (state_q == S_IDLE);
    assign instr_o       = instr_q;
    assign exec_o        = exec_q;
    assign iter_load_o   = (state_q == S_EXEC) && exec_q.op.iter;
    assign cnt_clear_o   = (state_q == S_EXEC) && exec_q.op.iter;
    assign iter_step_o   = (state_q == S_ITER);
    assign res_valid_o   = (state_q == S_DONE);
    assign res_o         = res_q;

    // write-back happens on the result handshake edge
    assign wr_en_o   = res_valid_o && res_ready_i && !res_q.illegal;
    assign wr_addr_o = res_q.rd;
    assign wr_data_o = res_q.value;

    res_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o)))
        else $error("result changed or dropped before it was taken");

    // after an accept, the next accept waits for the result handshake
    one_in_flight_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (instr_valid_i && instr_ready_o) |=>
            (!instr_ready_o until (res_valid_o && res_ready_i)))
        else $error("new instruction accepted while a result is pending");

endmodule

/* design/bit_step_counter.sv */
// step counter for the iterative unit: counts 32 steps and flags the last one
`timescale 1ns/1ps
`include "rv_dec_defs.svh"

module bit_step_counter (
    input  logic clk_i,
    input  logic rst_i,
    input  logic clear_i,
    input  logic step_i,
    output logic last_o
);
    localparam int CNT_W = $clog2(`XLEN_W);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            cnt_q <= '0;
        end else if (step_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign last_o = (cnt_q == CNT_W'(`XLEN_W - 1));

    // once the last step is taken, no more steps until the next clear
    no_overrun_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (step_i && last_o) |=> (!step_i until clear_i))
        else $error("step after last without clear");

endmodule

/* design/alu_single.sv */
// single-cycle execute unit: arithmetic, logic, shift, compare, lui, pkg and sladd
`timescale 1ns/1ps
`include "rv_dec_defs.svh"

module alu_single (
    input  rv_dec_pkg::exec_op_t exec_i,
    output logic [`XLEN_W-1:0]   value_o
);
    import rv_dec_pkg::*;

    localparam int HALF_W = `XLEN_W / 2;

    logic [`XLEN_W-1:0] a;
    logic [`XLEN_W-1:0] b;
    logic [4:0]         shamt;

    assign a     = exec_i.a;
    assign b     = exec_i.op.use_imm ? exec_i.op.imm : exec_i.b;
    assign shamt = b[4:0];

    always_comb begin
        case (exec_i.op.uop)
            UOP_ADD,  UOP_ADDI: value_o = a + b;
            UOP_SUB:            value_o = a - b;
            UOP_AND,  UOP_ANDI: value_o = a & b;
            UOP_OR,   UOP_ORI:  value_o = a | b;
            UOP_XOR,  UOP_XORI: value_o = a ^ b;
            UOP_SLL,  UOP_SLLI: value_o = a << shamt;
            UOP_SRL,  UOP_SRLI: value_o = a >> shamt;
            UOP_SRA,  UOP_SRAI: value_o = $signed(a) >>> shamt;
            UOP_SLT,  UOP_SLTI: begin
                value_o = {{(`XLEN_W-1){1'b0}}, $signed(a) < $signed(b)};
            end
            UOP_SLTU, UOP_SLTIU: begin
                value_o = {{(`XLEN_W-1){1'b0}}, a < b};
            end
            // immediate is already shifted into the upper bits
            UOP_LUI:   value_o = exec_i.op.imm;
            UOP_PKG:   value_o = {b[HALF_W-1:0], a[HALF_W-1:0]};
            UOP_SLADD: value_o = (a << 1) + b;
            // illegal and iterative ops are not handled here
            default:   value_o = '0;
        endcase
    end

endmodule

/* design/bit_iter_unit.sv */
// iterative bit engine: zero count, population count, hamming distance and bit reverse
`timescale 1ns/1ps
`include "rv_dec_defs.svh"

module bit_iter_unit (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 load_i,
    input  logic                 step_i,
    input  rv_dec_pkg::exec_op_t exec_i,
    output logic [`XLEN_W-1:0]   value_o
);
    import rv_dec_pkg::*;

    logic [`XLEN_W-1:0] work_q;
    logic [`XLEN_W-1:0] acc_q;
    logic [`XLEN_W-1:0] acc_d;
    logic               bit0;

    assign bit0 = work_q[0];

    // accumulator after examining the current low bit
    always_comb begin
        case (exec_i.op.uop)
            UOP_CNTZ:  acc_d = acc_q + {{(`XLEN_W-1){1'b0}}, ~bit0};
            UOP_CNTP,
            UOP_HMDST: acc_d = acc_q + {{(`XLEN_W-1){1'b0}}, bit0};
            // first bit examined ends up at the top after all steps
            UOP_RVRS:  acc_d = {acc_q[`XLEN_W-2:0], bit0};
            default:   acc_d = acc_q;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            work_q <= '0;
            acc_q  <= '0;
        end else if (load_i) begin
            work_q <= (exec_i.op.uop == UOP_HMDST) ? (exec_i.a ^ exec_i.b) : exec_i.a;
            acc_q  <= '0;
        end else if (step_i) begin
            work_q <= work_q >> 1;
            acc_q  <= acc_d;
        end
    end

    // includes the step in progress, so the last step's value is final
    assign value_o = acc_d;

endmodule

/* design/core_dec_top.sv */
// decode and register-read subsystem top: instruction stream in, result stream out
`timescale 1ns/1ps
`include "rv_dec_defs.svh"

module core_dec_top (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                instr_valid_i,
    input  logic [31:0]         instr_i,
    output logic                instr_ready_o,
    output logic                res_valid_o,
    output rv_dec_pkg::result_t res_o,
    input  logic                res_ready_i
);
    import rv_dec_pkg::*;

    logic [31:0]        instr_q;
    dec_op_t            dec_op;
    exec_op_t           exec_op;
    logic [`XLEN_W-1:0] rs1_val;
    logic [`XLEN_W-1:0] rs2_val;
    logic [`XLEN_W-1:0] alu_val;
    logic [`XLEN_W-1:0] iter_val;
    logic               iter_load;
    logic               iter_step;
    logic               cnt_clear;
    logic               cnt_last;
    logic               wr_en;
    logic [4:0]         wr_addr;
    logic [`XLEN_W-1:0] wr_data;

    issue_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .dec_i         (dec_op),
        .rs1_val_i     (rs1_val),
        .rs2_val_i     (rs2_val),
        .exec_o        (exec_op),
        .alu_val_i     (alu_val),
        .iter_load_o   (iter_load),
        .iter_step_o   (iter_step),
        .iter_val_i    (iter_val),
        .cnt_clear_o   (cnt_clear),
        .cnt_last_i    (cnt_last),
        .res_valid_o   (res_valid_o),
        .res_o         (res_o),
        .res_ready_i   (res_ready_i),
        .wr_en_o       (wr_en),
        .wr_addr_o     (wr_addr),
        .wr_data_o     (wr_data),
        .instr_o       (instr_q)
    );

    instr_decoder u_dec (
        .instr_i (instr_q),
        .dec_o   (dec_op)
    );

    reg_file u_rf (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rd_addr_a_i (dec_op.rs1),
        .rd_addr_b_i (dec_op.rs2),
        .rd_data_a_o (rs1_val),
        .rd_data_b_o (rs2_val),
        .wr_en_i     (wr_en),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data)
    );

    bit_step_counter u_cnt (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .clear_i (cnt_clear),
        .step_i  (iter_step),
        .last_o  (cnt_last)
    );

    alu_single u_alu (
        .exec_i  (exec_op),
        .value_o (alu_val)
    );

    bit_iter_unit u_iter (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .load_i  (iter_load),
        .step_i  (iter_step),
        .exec_i  (exec_op),
        .value_o (iter_val)
    );

endmodule

/* bench/tb_core_dec.sv */
// decode stage testbench: random instruction stream checked against a reference model
`timescale 1ns/1ps
`include "rv_dec_defs.svh"

module tb_core_dec;
    import rv_dec_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int INSTR_BUDGET   = 220;
    localparam int TIMEOUT_CYCLES = INSTR_BUDGET * 60 + RESET_CYCLES;

    logic        clk_i;
    logic        rst_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        instr_ready_o;
    logic        res_valid_o;
    result_t     res_o;
    logic        res_ready_i;

    logic [31:0] lfsr_q;
    logic [31:0] reg_model [0:31];
    logic [31:0] pending_q [$];
    int          cyc;
    int          accept_edge;
    int          sent_cnt;
    int          results_cnt;
    logic        bp_mode;
    logic        valid_prev;
    logic        ready_prev;
    result_t     held_res;
    result_t     exp_res;

    core_dec_top dut0 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .res_valid_o   (res_valid_o),
        .res_o         (res_o),
        .res_ready_i   (res_ready_i)
    );

    always #5 clk_i = ~clk_i;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `OPC_LUI};
    endfunction

    function automatic logic is_iter(input logic [31:0] word);
        return word[6:0] == `OPC_CUSTOM0 && word[31:25] == 7'h00 && word[14:12] < 3'd4;
    endfunction

    // expected result from the instruction word and the register model
    function automatic result_t expected_result(input logic [31:0] word);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] rb;
        logic [31:0] imm;
        logic [31:0] val;
        logic        ok;
        result_t     r;
        f3  = word[14:12];
        f7  = word[31:25];
        a   = reg_model[word[19:15]];
        rb  = reg_model[word[24:20]];
        imm = {{20{word[31]}}, word[31:20]};
        val = '0;
        ok  = 1'b1;
        case (word[6:0])
            `OPC_OP: begin
                if (f7 == 7'h00) begin
                    case (f3)
                        3'd0: val = a + rb;
                        3'd1: val = a << rb[4:0];
                        3'd2: val = ($signed(a) < $signed(rb)) ? 32'd1 : 32'd0;
                        3'd3: val = (a < rb) ? 32'd1 : 32'd0;
                        3'd4: val = a ^ rb;
                        3'd5: val = a >> rb[4:0];
                        3'd6: val = a | rb;
                        default: val = a & rb;
                    endcase
                end else if (f7 == 7'h20 && f3 == 3'd0) begin
                    val = a - rb;
                end else if (f7 == 7'h20 && f3 == 3'd5) begin
                    val = $signed(a) >>> rb[4:0];
                end else begin
                    ok = 1'b0;
                end
            end
            `OPC_OP_IMM: begin
                case (f3)
                    3'd0: val = a + imm;
                    3'd2: val = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                    3'd3: val = (a < imm) ? 32'd1 : 32'd0;
                    3'd4: val = a ^ imm;
                    3'd6: val = a | imm;
                    3'd7: val = a & imm;
                    3'd1: begin
                        if (f7 == 7'h00) val = a << imm[4:0];
                        else ok = 1'b0;
                    end
                    default: begin
                        if (f7 == 7'h00) val = a >> imm[4:0];
                        else if (f7 == 7'h20) val = $signed(a) >>> imm[4:0];
                        else ok = 1'b0;
                    end
                endcase
            end
            `OPC_LUI: val = {word[31:12], 12'h000};
            `OPC_CUSTOM0: begin
                if (f7 != 7'h00) begin
                    ok = 1'b0;
                end else begin
                    case (f3)
                        `F3_CNTZ:  for (int i = 0; i < 32; i++) val = val + {31'b0, ~a[i]};
                        `F3_CNTP:  for (int i = 0; i < 32; i++) val = val + {31'b0, a[i]};
                        `F3_RVRS:  for (int i = 0; i < 32; i++) val[31-i] = a[i];
                        `F3_HMDST: for (int i = 0; i < 32; i++) val = val + {31'b0, a[i] ^ rb[i]};
                        `F3_PKG:   val = {rb[15:0], a[15:0]};
                        `F3_SLADD: val = (a << 1) + rb;
                        default:   ok = 1'b0;
                    endcase
                end
            end
            default: ok = 1'b0;
        endcase
        r.rd      = word[11:7];
        r.value   = ok ? val : 32'd0;
        r.illegal = ~ok;
        return r;
    endfunction

    task abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task check_result(input result_t got, input result_t exp);
        if (got.rd !== exp.rd) begin
            $display("FAIL res_o.rd got %h expected %h", got.rd, exp.rd);
            abort_run();
        end else if (got.value !== exp.value) begin
            $display("FAIL res_o.value got %h expected %h", got.value, exp.value);
            abort_run();
        end else if (got.illegal !== exp.illegal) begin
            $display("FAIL res_o.illegal got %h expected %h", got.illegal, exp.illegal);
            abort_run();
        end
    endtask

    task check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // called 1 ns after a rising edge; returns 1 ns after the result handshake edge
    task send_instr(input logic [31:0] word);
        logic accepted;
        logic taken;
        accepted      = 1'b0;
        taken         = 1'b0;
        instr_i       = word;
        instr_valid_i = 1'b1;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = instr_ready_o;
            @(posedge clk_i);
            #1;
        end
        instr_valid_i = 1'b0;
        instr_i       = '0;
        while (!taken) begin
            res_ready_i = bp_mode ? (take_bits(2) == 32'd3) : 1'b1;
            @(negedge clk_i);
            taken = res_valid_o && res_ready_i;
            @(posedge clk_i);
            #1;
        end
        res_ready_i = 1'b0;
        sent_cnt++;
    endtask

    function logic [31:0] random_alu();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        f3  = take_bits(3);
        rs1 = take_bits(5);
        rs2 = take_bits(5);
        rd  = take_bits(5);
        if (take_bits(1) == 32'd1) begin
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && take_bits(1) == 32'd1) ? 7'h20 : 7'h00;
            return r_type(f7, rs2, rs1, f3, rd, `OPC_OP);
        end
        imm = take_bits(12);
        if (f3 == 3'd1) begin
            imm[11:5] = 7'h00;
        end else if (f3 == 3'd5) begin
            imm[11:5] = (take_bits(1) == 32'd1) ? 7'h20 : 7'h00;
        end
        return i_type(imm, rs1, f3, rd);
    endfunction

    function logic [31:0] random_custom(input logic [2:0] f3);
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        rs1 = take_bits(5);
        rs2 = take_bits(5);
        rd  = take_bits(5);
        return r_type(7'h00, rs2, rs1, f3, rd, `OPC_CUSTOM0);
    endfunction

    function logic [31:0] random_illegal();
        logic [1:0]  kind;
        logic [31:0] w;
        logic [6:0]  f7;
        kind = take_bits(2);
        w    = take_bits(32);
        case (kind)
            2'd0: begin
                // accepted opcodes all have bit 6 clear
                if (w[6:0] == `OPC_OP || w[6:0] == `OPC_OP_IMM ||
                    w[6:0] == `OPC_LUI || w[6:0] == `OPC_CUSTOM0) begin
                    w[6] = 1'b1;
                end
            end
            2'd1: begin
                f7 = take_bits(7);
                if (f7 == 7'h00) f7 = 7'h01;
                w = {f7, w[24:7], `OPC_CUSTOM0};
            end
            2'd2: w = {7'h00, w[24:15], 2'b11, w[12], w[11:7], `OPC_CUSTOM0};
            default: w = {7'h01, w[24:7], `OPC_OP};
        endcase
        return w;
    endfunction

    always @(posedge clk_i) begin
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end else begin
            cyc <= cyc + 1;
        end
    end

    // result monitor, samples at the falling edge where all signals are settled
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (instr_valid_i && instr_ready_o) begin
                pending_q.push_back(instr_i);
                accept_edge = cyc + 1;
            end
            if (res_valid_o) begin
                check_flag("instr_ready_o", instr_ready_o, 1'b0);
                if (pending_q.size() == 0) begin
                    $display("result offered with no instruction in flight");
                    abort_run();
                end else begin
                    if (!valid_prev) begin
                        check_count("result latency", cyc - accept_edge,
                                    is_iter(pending_q[0]) ? 34 : 2);
                    end else if (!ready_prev) begin
                        check_result(res_o, held_res);
                    end
                    if (res_ready_i) begin
                        exp_res = expected_result(pending_q.pop_front());
                        check_result(res_o, exp_res);
                        if (!exp_res.illegal && exp_res.rd != 5'd0) begin
                            reg_model[exp_res.rd] = exp_res.value;
                        end
                        results_cnt++;
                    end
                end
            end
            valid_prev = res_valid_o;
            ready_prev = res_ready_i;
            held_res   = res_o;
        end
    end

    initial begin
        clk_i         = 1'b0;
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        res_ready_i   = 1'b0;
        lfsr_q        = 32'd67573;
        cyc           = 0;
        accept_edge   = 0;
        sent_cnt      = 0;
        results_cnt   = 0;
        bp_mode       = 1'b0;
        valid_prev    = 1'b0;
        ready_prev    = 1'b0;
        held_res      = '0;
        for (int i = 0; i < 32; i++) reg_model[i] = '0;

        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        @(negedge clk_i);
        check_flag("instr_ready_o", instr_ready_o, 1'b1);
        check_flag("res_valid_o", res_valid_o, 1'b0);
        @(posedge clk_i);
        #1;

        // every register reads zero after reset
        for (int i = 0; i < 32; i++) send_instr(r_type(7'h00, 5'd0, i, 3'd0, i, `OPC_OP));

        // fill registers, odd ones by addi and even ones by lui
        for (int i = 1; i < 32; i++) begin
            if (i % 2 == 1) send_instr(i_type(take_bits(12), 5'd0, 3'd0, i));
            else send_instr(u_type(take_bits(20), i));
        end
        send_instr(i_type(take_bits(12), 5'd1, 3'd0, 5'd0));
        send_instr(r_type(7'h00, 5'd0, 5'd0, 3'd6, 5'd0, `OPC_OP));

        for (int n = 0; n < 60; n++) send_instr(random_alu());

        // corner operands in x1 and x2
        send_instr(i_type(12'h000, 5'd0, 3'd0, 5'd1));
        send_instr(i_type(12'hfff, 5'd0, 3'd0, 5'd2));
        for (int f = 0; f < 4; f++) begin
            send_instr(r_type(7'h00, 5'd2, 5'd1, f, 5'd3, `OPC_CUSTOM0));
            send_instr(r_type(7'h00, 5'd1, 5'd2, f, 5'd4, `OPC_CUSTOM0));
            send_instr(r_type(7'h00, 5'd2, 5'd2, f, 5'd5, `OPC_CUSTOM0));
        end
        for (int n = 0; n < 12; n++) send_instr(random_custom(take_bits(2)));

        for (int n = 0; n < 12; n++) send_instr(random_custom(3'd4 + take_bits(1)));
        for (int n = 0; n < 12; n++) send_instr(random_illegal());

        // read every register back into x0, illegal words must not have written any
        for (int i = 1; i < 32; i++) send_instr(r_type(7'h00, 5'd0, i, 3'd6, 5'd0, `OPC_OP));

        // random back-pressure on the result stream
        bp_mode = 1'b1;
        for (int n = 0; n < 12; n++) begin
            if (n % 3 == 0) send_instr(random_custom(take_bits(3) % 6));
            else send_instr(random_alu());
        end
        bp_mode = 1'b0;

        repeat (4) @(posedge clk_i);
        if (results_cnt == sent_cnt) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("only %0d of %0d results were checked", results_cnt, sent_cnt);
            abort_run();
        end
    end

endmodule

/* tb.f */
+incdir+include
design/rv_dec_pkg.sv
design/instr_decoder.sv
design/reg_file.sv
design/issue_ctrl.sv
design/bit_step_counter.sv
design/alu_single.sv
design/bit_iter_unit.sv
design/core_dec_top.sv
bench/tb_core_dec.sv
